//--- source/snd_pkg.sv
package snd_pkg;

    // host command byte, bit 7 unused
    // 0 stops playback, 1..127 pick a sample block
    typedef logic [7:0] cmd_t;

    // sample ROM byte address, block n at n*256
    typedef logic [14:0] rom_addr_t;

    // raw signed PCM byte as stored in ROM
    typedef logic signed [7:0] pcm_t;

    // effects gain in 4.4 fixed point, 0x10 is unity
    typedef logic [7:0] gain_t;

    // mixer output
    typedef logic signed [15:0] sample_t;

    // playback sequencer
    typedef enum logic [1:0] {
        IDLE,       // nothing playing
        FETCH,      // ROM read in flight
        HOLD,       // byte buffered, waits for the next tick
        WAIT_TICK   // restart fetch, or last byte of block on show
    } seq_state_t;

    // stops the block when read back
    localparam pcm_t PCM_END = 8'sh80;

    // fxlevel 0..3 -> 1/4, 3/8, 1/2, 3/4
    localparam gain_t GAIN_LEVEL [4] = '{8'h04, 8'h06, 8'h08, 8'h0C};

endpackage

//--- source/snd_latch.sv
module snd_latch import snd_pkg::*; (
    input  logic clk,
    input  logic arst_n,

    // host side
    input  logic req,
    input  cmd_t cmd,
    output logic ack,

    // towards the sequencer
    input  logic take,      // one cycle, frees the latch
    output logic pending,
    output cmd_t cmd_q
);

    logic grab;

    // new command only when the previous one was consumed
    // and the last handshake has fully closed
    assign grab = req && !ack && !pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack     <= 1'b0;
            pending <= 1'b0;
        end else begin
            // ack phases
            if (!req) begin
                ack <= 1'b0;        // host released req
            end else if (grab) begin
                ack <= 1'b1;
            end

            // take always wins, grab can't happen while pending
            if (take) begin
                pending <= 1'b0;
            end else if (grab) begin
                pending <= 1'b1;
            end
        end
    end

    // command byte itself
    always_ff @(posedge clk) begin
        if (grab) begin
            cmd_q <= cmd;
        end
    end

endmodule

//--- source/snd_timer.sv
module snd_timer #(
    parameter int SAMPLE_DIV = 64     // clocks per output sample
) (
    input  logic clk,
    input  logic arst_n,
    output logic tick
);

    // counter just wide enough for SAMPLE_DIV-1
    localparam int CW = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
    localparam logic [CW-1:0] RELOAD = CW'(SAMPLE_DIV - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= RELOAD;
            tick <= 1'b0;
        end else begin
            if (cnt == '0) begin
                cnt  <= RELOAD;     // wrap
                tick <= 1'b1;
            end else begin
                cnt  <= cnt - 1'b1;
                tick <= 1'b0;
            end
        end
    end

endmodule

//--- source/snd_seq.sv
module snd_seq import snd_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,

    // command latch
    input  logic      pending,
    input  cmd_t      cmd_q,
    output logic      take,

    input  logic      tick,

    // sample ROM
    output logic      rom_cs,
    output rom_addr_t rom_addr,
    input  pcm_t      rom_data,
    input  logic      rom_ok,

    output pcm_t      pcm_q,    // current sample towards the mixer
    output logic      busy
);

    seq_state_t state;
    rom_addr_t  addr;       // next byte to read
    rom_addr_t  base;
    logic       first;      // nothing read yet for this command
    logic       play;
    pcm_t       buf_q;      // fetched byte, shown on the next tick

    assign base = {cmd_q[6:0], 8'h00};
    assign play = cmd_q[6:0] != 7'd0;   // zero means stop

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            take     <= 1'b0;
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            addr     <= '0;
            first    <= 1'b0;
            pcm_q    <= '0;
            busy     <= 1'b0;
        end else begin
            take <= pending && !take;   // single pulse per command

            if (take) begin
                // new command, cuts whatever is playing
                pcm_q <= '0;
                first <= 1'b1;
                addr  <= base;
                busy  <= play;
                if (rom_cs && !rom_ok) begin
                    state <= FETCH;     // let the open read finish
                end else begin
                    rom_cs <= 1'b0;
                    state  <= play ? WAIT_TICK : IDLE;
                end
            end else begin
                case (state)
                    IDLE: begin
                        rom_cs <= 1'b0;
                    end
                    FETCH: begin
                        if (rom_ok) begin
                            rom_cs <= 1'b0;
                            if (!busy) begin
                                state <= IDLE;      // stopped mid read
                            end else if (first && rom_addr != addr) begin
                                state <= WAIT_TICK; // stale read, relaunch
                            end else begin
                                addr  <= addr + rom_addr_t'(1);
                                first <= 1'b0;
                                state <= HOLD;
                            end
                        end
                        // a tick here is an underrun, pcm_q just repeats
                    end
                    HOLD: begin
                        if (tick) begin
                            if (buf_q == PCM_END) begin
                                pcm_q <= '0;
                                busy  <= 1'b0;
                                state <= IDLE;
                            end else begin
                                pcm_q <= buf_q;
                                if (addr[7:0] == 8'd0) begin
                                    state <= WAIT_TICK; // block used up
                                end else begin
                                    rom_cs   <= 1'b1;
                                    rom_addr <= addr;
                                    state    <= FETCH;
                                end
                            end
                        end
                    end
                    WAIT_TICK: begin
                        if (first) begin
                            rom_cs   <= 1'b1;       // first read of the block
                            rom_addr <= addr;
                            state    <= FETCH;
                        end else if (tick) begin
                            pcm_q <= '0;            // last byte had its slot
                            busy  <= 1'b0;
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // stale data also lands here but HOLD is never entered with it
    always_ff @(posedge clk) begin
        if (rom_cs && rom_ok) begin
            buf_q <= rom_data;
        end
    end

endmodule

//--- source/snd_mixer.sv
module snd_mixer import snd_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,

    input  logic       tick,
    input  pcm_t       pcm_q,
    input  logic [1:0] fxlevel,
    input  logic       enable_pcm,
    input  logic       sound_en,

    output sample_t    snd,
    output logic       sample,      // one cycle per new snd value
    output logic       peak
);

    gain_t              sel_gain;
    gain_t              gain_q;
    logic signed [16:0] prod;
    logic signed [12:0] lvl;        // product in pcm units
    logic               clip_hi;
    logic               clip_lo;
    sample_t            sat_val;

    assign sel_gain = enable_pcm ? GAIN_LEVEL[fxlevel] : '0;

    // gain kept unsigned, zero bit in front
    assign prod = pcm_q * $signed({1'b0, gain_q});
    assign lvl  = prod[16:4];       // drop the 4 fraction bits

    // anything past 8 bits won't fit after the <<8
    assign clip_hi = lvl > 13'sd127;
    assign clip_lo = lvl < -13'sd128;

    always_comb begin
        if (clip_hi) begin
            sat_val = 16'sh7fff;
        end else if (clip_lo) begin
            sat_val = 16'sh8000;
        end else begin
            sat_val = {lvl[7:0], 8'h00};
        end
    end

    // gain and pcm_q both move on tick, product used one tick later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gain_q <= '0;
            snd    <= '0;
            sample <= 1'b0;
            peak   <= 1'b0;
        end else begin
            sample <= tick;
            if (tick) begin
                gain_q <= sel_gain;
                snd    <= sound_en ? sat_val : '0;   // muted board
                peak   <= sound_en && (clip_hi || clip_lo);
            end
        end
    end

endmodule

//--- source/snd_board.sv
module snd_board import snd_pkg::*; #(
    parameter int SAMPLE_DIV = 64
) (
    input  logic       clk,
    input  logic       arst_n,

    // host command port
    input  logic       req,
    input  cmd_t       cmd,
    output logic       ack,

    // options
    input  logic [1:0] fxlevel,
    input  logic       enable_pcm,
    input  logic       sound_en,

    // sample ROM
    output logic       rom_cs,
    output rom_addr_t  rom_addr,
    input  pcm_t       rom_data,
    input  logic       rom_ok,

    output sample_t    snd,
    output logic       sample,
    output logic       peak,
    output logic       busy
);

    logic pending;
    logic take;
    cmd_t cmd_q;
    logic tick;
    pcm_t pcm_q;

    snd_latch u_latch (
        .clk     ( clk      ),
        .arst_n  ( arst_n   ),
        .req     ( req      ),
        .cmd     ( cmd      ),
        .ack     ( ack      ),
        .take    ( take     ),
        .pending ( pending  ),
        .cmd_q   ( cmd_q    )
    );

    snd_timer #(.SAMPLE_DIV(SAMPLE_DIV)) u_timer (
        .clk     ( clk      ),
        .arst_n  ( arst_n   ),
        .tick    ( tick     )  // paces sequencer and mixer alike
    );

    snd_seq u_seq (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pending  ( pending  ),
        .cmd_q    ( cmd_q    ),
        .take     ( take     ),
        .tick     ( tick     ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .pcm_q    ( pcm_q    ),
        .busy     ( busy     )
    );

    snd_mixer u_mixer (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .tick       ( tick       ),
        .pcm_q      ( pcm_q      ),
        .fxlevel    ( fxlevel    ),
        .enable_pcm ( enable_pcm ),
        .sound_en   ( sound_en   ),
        .snd        ( snd        ),
        .sample     ( sample     ),
        .peak       ( peak       )
    );

endmodule

//--- test/snd_properties.sv
module snd_properties import snd_pkg::*; (
    input logic      clk,
    input logic      arst_n,
    input logic      req,
    input logic      ack,
    input logic      rom_cs,
    input rom_addr_t rom_addr,
    input logic      rom_ok,
    input logic      tick,      // internal timer strobe
    input logic      sample,
    input logic      peak,
    input logic      busy,
    input sample_t   snd
);

    int fails = 0;      // read back by the testbench

    // ROM request frozen until answered
    a_cs_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            $error("rom_cs or rom_addr changed before rom_ok");
            fails++;
        end

    a_cs_drop: assert property (@(posedge clk) disable iff (!arst_n)
        rom_cs && rom_ok |=> !rom_cs)
        else begin
            $error("rom_cs still high after rom_ok");
            fails++;
        end

    a_sample_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        sample |=> !sample)
        else begin
            $error("sample wider than one cycle");
            fails++;
        end

    a_tick_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        tick |=> !tick)
        else begin
            $error("tick wider than one cycle");
            fails++;
        end

    // four-phase edges
    a_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> req)
        else begin
            $error("ack rose without req");
            fails++;
        end

    a_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ack) |-> $past(!req))
        else begin
            $error("ack fell while req was still high");
            fails++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n && $past(!arst_n) |-> !ack && !rom_cs && !busy && !sample && !peak && snd == '0)
        else begin
            $error("outputs active during reset");
            fails++;
        end

endmodule

bind snd_board snd_properties u_props (
    .clk      ( clk      ),
    .arst_n   ( arst_n   ),
    .req      ( req      ),
    .ack      ( ack      ),
    .rom_cs   ( rom_cs   ),
    .rom_addr ( rom_addr ),
    .rom_ok   ( rom_ok   ),
    .tick     ( tick     ),
    .sample   ( sample   ),
    .peak     ( peak     ),
    .busy     ( busy     ),
    .snd      ( snd      )
);

//--- test/snd_checker.sv
module snd_checker import snd_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ack,
    input  cmd_t       cmd,
    input  logic [1:0] fxlevel,
    input  logic       enable_pcm,
    input  logic       sound_en,
    input  logic       rom_cs,
    input  rom_addr_t  rom_addr,
    input  logic       rom_ok,
    input  sample_t    snd,
    input  logic       sample,
    input  logic       peak,
    input  logic       busy,
    output int         errors
);

    localparam int GAIN [4] = '{4, 6, 8, 12};  // 4.4 gains per fxlevel

    logic [6:0] blk;        // block of the last accepted command
    logic       ack_d;
    int         hold;       // cycles in which snd may still carry the old block
    int         phase;      // 0 no fetch, 1 fetch done, 2 one zero left, 3 streaming
    int         k;          // next byte offset in the block
    int         gain_prev;  // gain registered on the previous tick
    int         b;
    int         exp_snd;
    logic       exp_pk;
    logic       exp_busy;

    // byte k of block n, end marker at n+3
    function automatic int rom_byte(input int n, input int k);
        if (k == n + 3) begin
            return -128;
        end
        return ((k * 5 + n) % 127) + 1;
    endfunction

    function automatic int level(input int b, input int g);
        return (b * g) >>> 4;   // 1/16 per gain unit
    endfunction

    always @(negedge clk) begin
        if (!arst_n) begin
            blk = '0;
            ack_d = 1'b0;
            hold = 0;
            phase = 0;
            k = 0;
            gain_prev = 0;
            errors = 0;
        end else begin
            if (ack && !ack_d) begin
                blk = cmd[6:0];     // new command, restart the stream
                hold = 3;           // old pcm_q may reach snd until take lands
                phase = 0;
                k = 0;
            end
            ack_d = ack;

            if (sample) begin
                if (hold == 0) begin
                    b = 0;
                    exp_busy = blk != 0;    // high from take on
                    if (blk != 0 && phase == 3) begin
                        b = rom_byte(blk, k);
                        exp_busy = k < int'(blk) + 2;   // low once the marker is read
                        if (b == -128) begin
                            b = 0;          // silence after the marker
                        end else begin
                            k++;
                        end
                    end
                    exp_pk = sound_en && (level(b, gain_prev) > 127 ||
                                          level(b, gain_prev) < -128);
                    if (!sound_en) begin
                        exp_snd = 0;
                    end else if (level(b, gain_prev) > 127) begin
                        exp_snd = 32767;
                    end else if (level(b, gain_prev) < -128) begin
                        exp_snd = -32768;
                    end else begin
                        exp_snd = level(b, gain_prev) * 256;
                    end
                    if (int'(snd) != exp_snd) begin
                        $display("FAIL %0t: block %0d byte %0d snd %0d expected %0d",
                                 $time, blk, k, snd, exp_snd);
                        errors++;
                    end
                    if (peak != exp_pk) begin
                        $display("FAIL %0t: block %0d peak %0b expected %0b",
                                 $time, blk, peak, exp_pk);
                        errors++;
                    end
                    if (busy != exp_busy) begin
                        $display("FAIL %0t: block %0d busy %0b expected %0b",
                                 $time, blk, busy, exp_busy);
                        errors++;
                    end
                    if (phase == 2) begin
                        phase = 3;          // byte 0 shows on the next one
                    end
                end
                gain_prev = enable_pcm ? GAIN[fxlevel] : 0;
            end
            if (hold > 0) begin
                hold--;
            end

            // sequencer sits in HOLD from the cycle after the handover
            if (phase == 1) begin
                phase = 2;
            end

            // first byte of the block handed over
            if (rom_cs && rom_ok && phase == 0 && blk != 0 && rom_addr == {blk, 8'h00}) begin
                phase = 1;
            end
        end
    end

endmodule

//--- test/tb_snd_board.sv
module tb_snd_board import snd_pkg::*; ();

    typedef struct packed {
        cmd_t       cmd;
        logic [1:0] fx;
        logic       en;
        logic       on;
        logic [7:0] cut;    // samples before the next row, 0 waits for busy low
    } row_t;

    logic       clk;
    logic       arst_n;
    logic       req;
    cmd_t       cmd;
    logic       ack;
    logic [1:0] fxlevel;
    logic       enable_pcm;
    logic       sound_en;
    logic       rom_cs;
    rom_addr_t  rom_addr;
    pcm_t       rom_data;
    logic       rom_ok;
    sample_t    snd;
    logic       sample;
    logic       peak;
    logic       busy;

    int         seed = 66;
    int         rom_wait;
    logic       rom_run;
    int         value_errors;
    int         timeouts = 0;

    row_t rows [11] = '{
        '{8'd1,   2'd2, 1'b1, 1'b1, 8'd0},     // block 1, half level
        '{8'd5,   2'd0, 1'b1, 1'b1, 8'd0},
        '{8'd20,  2'd1, 1'b1, 1'b1, 8'd0},
        '{8'd5,   2'd3, 1'b1, 1'b1, 8'd0},
        '{8'd20,  2'd2, 1'b0, 1'b1, 8'd0},     // pcm gain off
        '{8'd5,   2'd2, 1'b1, 1'b0, 8'd0},     // board muted
        '{8'd127, 2'd3, 1'b1, 1'b1, 8'd0},     // loudest block, top level
        '{8'd20,  2'd2, 1'b1, 1'b1, 8'd6},
        '{8'd0,   2'd2, 1'b1, 1'b1, 8'd0},     // stop mid block
        '{8'd20,  2'd3, 1'b1, 1'b1, 8'd5},
        '{8'd5,   2'd3, 1'b1, 1'b1, 8'd0}      // cuts block 20
    };

    snd_board DUT (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .req        ( req        ),
        .cmd        ( cmd        ),
        .ack        ( ack        ),
        .fxlevel    ( fxlevel    ),
        .enable_pcm ( enable_pcm ),
        .sound_en   ( sound_en   ),
        .rom_cs     ( rom_cs     ),
        .rom_addr   ( rom_addr   ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .snd        ( snd        ),
        .sample     ( sample     ),
        .peak       ( peak       ),
        .busy       ( busy       )
    );

    snd_checker u_check (
        .clk        ( clk          ),
        .arst_n     ( arst_n       ),
        .ack        ( ack          ),
        .cmd        ( cmd          ),
        .fxlevel    ( fxlevel      ),
        .enable_pcm ( enable_pcm   ),
        .sound_en   ( sound_en     ),
        .rom_cs     ( rom_cs       ),
        .rom_addr   ( rom_addr     ),
        .rom_ok     ( rom_ok       ),
        .snd        ( snd          ),
        .sample     ( sample       ),
        .peak       ( peak         ),
        .busy       ( busy         ),
        .errors     ( value_errors )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // block n at n*256, marker at offset n+3
    function automatic pcm_t rom_byte(input rom_addr_t a);
        int n;
        int k;
        n = a[14:8];
        k = a[7:0];
        if (k == n + 3) begin
            return PCM_END;
        end
        return pcm_t'(((k * 5 + n) % 127) + 1);
    endfunction

    // sample ROM, answers after 1..8 cycles
    always @(posedge clk) begin
        if (!arst_n) begin
            rom_ok  <= 1'b0;
            rom_run <= 1'b0;
        end else if (rom_ok) begin
            rom_ok <= 1'b0;                     // cs drops on this edge
        end else if (rom_cs && !rom_run) begin
            rom_run  <= 1'b1;
            rom_wait <= 1 + ($unsigned($random(seed)) % 8);
        end else if (rom_run) begin
            if (rom_wait <= 1) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_byte(rom_addr);
                rom_run  <= 1'b0;
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    task automatic send_cmd(input cmd_t c);
        int t;
        @(posedge clk);
        cmd <= c;
        req <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!ack && t < 100);
        if (!ack) begin
            $display("timeout: no ack for command %0d", c);
            timeouts++;
        end
        @(posedge clk);
        req <= 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (ack && t < 100);
        if (ack) begin
            $display("timeout: ack stuck high after req dropped");
            timeouts++;
        end
    endtask

    task automatic wait_samples(input int count);
        int seen;
        int t;
        seen = 0;
        t = 0;
        while (seen < count && t < 200 * count) begin
            @(negedge clk);
            t++;
            if (sample) begin
                seen++;
            end
        end
        if (seen < count) begin
            $display("timeout: only %0d of %0d sample pulses came", seen, count);
            timeouts++;
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (busy && t < 20000) begin
            @(negedge clk);
            t++;
        end
        if (busy) begin
            $display("timeout: busy never fell");
            timeouts++;
        end
    endtask

    initial begin
        arst_n = 1'b0;
        req = 1'b0;
        cmd = '0;
        fxlevel = 2'd0;
        enable_pcm = 1'b0;
        sound_en = 1'b0;
        rom_ok = 1'b0;
        rom_data = '0;
        rom_wait = 0;
        rom_run = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            fxlevel    <= rows[i].fx;
            enable_pcm <= rows[i].en;
            sound_en   <= rows[i].on;
            send_cmd(rows[i].cmd);
            if (rows[i].cut != 0) begin
                wait_samples(rows[i].cut);  // next row interrupts
            end else begin
                wait_idle();
                wait_samples(2);            // silence after the block
            end
        end

        $display("closing: %0d value errors, %0d assertion failures, %0d timeouts",
                 value_errors, DUT.u_props.fails, timeouts);
        if (value_errors == 0 && DUT.u_props.fails == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- flist.f
source/snd_pkg.sv
source/snd_latch.sv
source/snd_timer.sv
source/snd_seq.sv
source/snd_mixer.sv
source/snd_board.sv
test/snd_properties.sv
test/snd_checker.sv
test/tb_snd_board.sv
